// File: Bender.yml
package:
  name: crc_fprint

sources:
  # package first, then leaf modules, then the top level
  - verilog/crc_pkg.sv
  - verilog/crc_word_counter.sv
  - verilog/crc_fsm.sv
  - verilog/crc_engine.sv
  - verilog/crc_result_port.sv
  - verilog/crc_fprint_top.sv

  - target: simulation
    files:
      - verif/crc_fprint_tb.sv

// File: sim.f
verilog/crc_pkg.sv
verilog/crc_word_counter.sv
verilog/crc_fsm.sv
verilog/crc_engine.sv
verilog/crc_result_port.sv
verilog/crc_fprint_top.sv
verif/crc_fprint_tb.sv

// File: verif/crc_fprint_tb.sv
`timescale 1ns/1ps

module crc_fprint_tb;

	import crc_pkg::*;

	// cycles any single wait may take before the run is abandoned
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst;
	logic wrte;
	data_word_t wdata;
	logic en_fprint;
	logic pause;
	logic unpause;
	logic res_req;
	crc_word_t res_data;
	logic res_ack;
	logic overrun;

	integer seed = 66020;
	int check_count = 0;
	int error_count = 0;

	// expected results in delivery order
	crc_word_t expected_q[$];

	// words of the block being written
	data_word_t block_data [BLOCK_WORDS];

	crc_fprint_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.wrte      (wrte),
		.wdata     (wdata),
		.en_fprint (en_fprint),
		.pause     (pause),
		.unpause   (unpause),
		.res_req   (res_req),
		.res_data  (res_data),
		.res_ack   (res_ack),
		.overrun   (overrun)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		fsm_state_t state;
		state = u_dut.u_fsm.state_q;
		$display("timeout at %0t: %s, fsm in %s", $time, what, state.name());
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("CHECKS FAILED");
		$finish;
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = {$random(seed)} % (hi - lo + 1);
		return lo + r;
	endfunction

	// msb first crc-32 with word and register both 32 bits wide
	// so the word can be folded into the register before shifting
	function automatic crc_word_t model_step(input crc_word_t crc_in, input data_word_t word);
		crc_word_t crc;
		crc = crc_in ^ word;
		for (int b = 0; b < 32; b++) begin
			if (crc[31]) begin
				crc = (crc << 1) ^ CRC_POLY;
			end else begin
				crc = crc << 1;
			end
		end
		return crc;
	endfunction

	// crc over the first n words of block_data
	function automatic crc_word_t model_crc(input int n_words);
		crc_word_t crc;
		crc = CRC_SEED;
		for (int i = 0; i < n_words; i++) begin
			crc = model_step(crc, block_data[i]);
		end
		return crc;
	endfunction

	task automatic fill_block();
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			block_data[i] = $random(seed);
		end
	endtask

	// all stimulus starts and ends 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic write_word(input data_word_t data);
		wrte = 1'b1;
		wdata = data;
		@(posedge clk);
		#1;
		wrte = 1'b0;
	endtask

	// words first..last-1 of block_data with random idle gaps up to max_gap
	task automatic write_words(input int first, input int last, input int max_gap);
		for (int i = first; i < last; i++) begin
			write_word(block_data[i]);
			if (max_gap > 0 && i < last - 1) begin
				idle_cycles(rand_range(0, max_gap));
			end
		end
	endtask

	// one cycle pause or unpause pulse to the fsm
	task automatic send_pulse(input logic resume);
		if (resume) begin
			unpause = 1'b1;
		end else begin
			pause = 1'b1;
		end
		@(posedge clk);
		#1;
		pause = 1'b0;
		unpause = 1'b0;
	endtask

	// writes with en_fprint low where no result may show up
	task automatic write_disabled(input int n);
		en_fprint = 1'b0;
		repeat (n) begin
			wrte = 1'b1;
			wdata = $random(seed);
			@(posedge clk);
			#1;
			check_value("res_req", 1'b0, res_req);
		end
		wrte = 1'b0;
	endtask

	// host side of the four phase handshake
	task automatic serve_result(input int delay);
		int waited;
		crc_word_t expected;
		waited = 0;
		while (!res_req && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!res_req) begin
			report_timeout("res_req never rose for an expected result");
		end else begin
			if (expected_q.size() == 0) begin
				error_count++;
				$display("result %h offered at %0t with no block pending", res_data, $time);
			end else begin
				expected = expected_q.pop_front();
				check_value("res_data", expected, res_data);
			end
			idle_cycles(delay);
			res_ack = 1'b1;
			waited = 0;
			while (res_req && waited < WAIT_LIMIT) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (res_req) begin
				report_timeout("res_req stayed high after res_ack");
			end else begin
				res_ack = 1'b0;
			end
		end
	endtask

	task automatic run_after_reset();
		check_value("res_req", 1'b0, res_req);
		check_value("overrun", 1'b0, overrun);
		write_disabled(20);
	endtask

	// consecutive blocks reseed through first_write
	task automatic run_back_to_back();
		en_fprint = 1'b1;
		fork
			begin
				for (int b = 0; b < 4; b++) begin
					fill_block();
					expected_q.push_back(model_crc(BLOCK_WORDS));
					write_words(0, BLOCK_WORDS, 0);
				end
			end
			begin
				repeat (4) serve_result(rand_range(0, 4));
			end
		join
		en_fprint = 1'b0;
		idle_cycles(2);
	endtask

	// same data with and without gaps
	task automatic run_gapped();
		en_fprint = 1'b1;
		fork
			begin
				for (int r = 0; r < 2; r++) begin
					fill_block();
					expected_q.push_back(model_crc(BLOCK_WORDS));
					expected_q.push_back(model_crc(BLOCK_WORDS));
					write_words(0, BLOCK_WORDS, 3);
					write_words(0, BLOCK_WORDS, 0);
				end
			end
			begin
				repeat (4) serve_result(rand_range(0, 4));
			end
		join
		en_fprint = 1'b0;
		idle_cycles(2);
	endtask

	// partial blocks flush and a drop at count zero reports nothing
	task automatic run_partial();
		int k;
		fork
			begin
				for (int r = 0; r < 2; r++) begin
					en_fprint = 1'b1;
					k = rand_range(1, BLOCK_WORDS - 1);
					fill_block();
					expected_q.push_back(model_crc(k));
					write_words(0, k, 0);
					en_fprint = 1'b0;
					// task_done must pass and the host gets a block time for the result
					idle_cycles(BLOCK_WORDS);
				end
				en_fprint = 1'b1;
				fill_block();
				expected_q.push_back(model_crc(BLOCK_WORDS));
				write_words(0, BLOCK_WORDS, 0);
				en_fprint = 1'b0;
			end
			begin
				repeat (3) serve_result(rand_range(0, 4));
			end
		join
		write_disabled(20);
	endtask

	// pause mid block keeps count and running crc
	task automatic run_pause();
		int k;
		en_fprint = 1'b1;
		fork
			begin
				for (int r = 0; r < 2; r++) begin
					fill_block();
					expected_q.push_back(model_crc(BLOCK_WORDS));
					k = rand_range(1, BLOCK_WORDS - 1);
					write_words(0, k, 0);
					send_pulse(1'b0);
					// a parked block is not flushed when the enable falls
					en_fprint = 1'b0;
					idle_cycles(rand_range(2, 6));
					en_fprint = 1'b1;
					send_pulse(1'b1);
					write_words(k, BLOCK_WORDS, 0);
				end
			end
			begin
				repeat (2) serve_result(rand_range(0, 4));
			end
		join
		en_fprint = 1'b0;
		idle_cycles(2);
	endtask

	// host stalls while the second and third results are lost
	task automatic run_overrun();
		en_fprint = 1'b1;
		for (int b = 0; b < 3; b++) begin
			fill_block();
			if (b == 0) begin
				expected_q.push_back(model_crc(BLOCK_WORDS));
			end
			write_words(0, BLOCK_WORDS, 0);
		end
		en_fprint = 1'b0;
		idle_cycles(2);
		check_value("overrun", 1'b1, overrun);
		check_value("res_req", 1'b1, res_req);
		serve_result(0);
		write_disabled(30);
		// sticky until reset
		check_value("overrun", 1'b1, overrun);
	endtask

	initial begin
		rst = 1'b1;
		wrte = 1'b0;
		wdata = '0;
		en_fprint = 1'b0;
		pause = 1'b0;
		unpause = 1'b0;
		res_ack = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_cycles(2);

		run_after_reset();
		run_back_to_back();
		run_gapped();
		run_partial();
		run_pause();
		// host kept up so far
		check_value("overrun", 1'b0, overrun);
		run_overrun();
		check_value("expected results left", 0, expected_q.size());

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/crc_engine.sv
`timescale 1ns/1ps

module crc_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                en_fcs,
	input  logic                sel,
	input  crc_pkg::data_word_t wdata,
	output crc_pkg::crc_word_t  crc_next
);

	import crc_pkg::*;

	// one data word pushed through the lfsr, msb first
	function automatic crc_word_t crc_update(input crc_word_t crc_in, input data_word_t data);
		crc_word_t crc;
		logic feedback;
		crc = crc_in;
		for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
			feedback = crc[CRC_WIDTH-1] ^ data[i];
			crc = {crc[CRC_WIDTH-2:0], 1'b0};
			if (feedback) begin
				crc = crc ^ CRC_POLY;
			end
		end
		return crc;
	endfunction

	// running crc of the open block
	crc_word_t crc_q;

	// start value for this word
	crc_word_t crc_start;

	// sel low means this word opens a new block
	assign crc_start = sel ? crc_q : CRC_SEED;

	// value loaded at this edge
	// on a flush without a word this is the partial crc itself
	assign crc_next = en_fcs ? crc_update(crc_start, wdata) : crc_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_q <= CRC_SEED;
		end else if (en_fcs) begin
			crc_q <= crc_next;
		end
	end

endmodule

// File: verilog/crc_fprint_top.sv
`timescale 1ns/1ps

module crc_fprint_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                wrte,
	input  crc_pkg::data_word_t wdata,
	input  logic                en_fprint,
	input  logic                pause,
	input  logic                unpause,
	output logic                res_req,
	output crc_pkg::crc_word_t  res_data,
	input  logic                res_ack,
	output logic                overrun
);

	import crc_pkg::*;

	// word strobe and seed select from the fsm
	logic en_fcs;
	logic sel;

	// block complete or flushed
	logic crc_ready;

	// word position feedback to the fsm
	word_count_t count;
	logic count_max;

	// engine value for this edge
	crc_word_t crc_next;

	crc_word_counter u_counter (
		.clk       (clk),
		.rst       (rst),
		.en_fcs    (en_fcs),
		.crc_ready (crc_ready),
		.count     (count),
		.count_max (count_max)
	);

	crc_fsm u_fsm (
		.clk       (clk),
		.rst       (rst),
		.wrte      (wrte),
		.en_fprint (en_fprint),
		.pause     (pause),
		.unpause   (unpause),
		.count     (count),
		.count_max (count_max),
		.en_fcs    (en_fcs),
		.sel       (sel),
		.crc_ready (crc_ready)
	);

	crc_engine u_engine (
		.clk      (clk),
		.rst      (rst),
		.en_fcs   (en_fcs),
		.sel      (sel),
		.wdata    (wdata),
		.crc_next (crc_next)
	);

	// result leaves one cycle after crc_ready when the slot is free
	crc_result_port u_result (
		.clk       (clk),
		.rst       (rst),
		.crc_ready (crc_ready),
		.crc_next  (crc_next),
		.res_ack   (res_ack),
		.res_req   (res_req),
		.res_data  (res_data),
		.overrun   (overrun)
	);

endmodule

// File: verilog/crc_fsm.sv
`timescale 1ns/1ps

module crc_fsm (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wrte,
	input  logic                 en_fprint,
	input  logic                 pause,
	input  logic                 unpause,
	input  crc_pkg::word_count_t count,
	input  logic                 count_max,
	output logic                 en_fcs,
	output logic                 sel,
	output logic                 crc_ready
);

	import crc_pkg::*;

	fsm_state_t state_q;
	fsm_state_t state_d;

	// a write that may be absorbed in any active state
	logic write_ok;

	// nonzero count means a block is partly written
	logic block_open;

	// pause pulse blocks absorption for its own cycle
	assign write_ok = wrte && en_fprint && !pause;
	assign block_open = (count != '0);

	// word strobe to counter and engine
	always_comb begin
		case (state_q)
			// parked init holds a partial block and must not reseed over it
			ST_INIT: en_fcs = write_ok && !block_open;
			ST_FIRST_WRITE: en_fcs = write_ok;
			ST_BLOCK_DONE: en_fcs = write_ok;
			ST_WRITE: en_fcs = write_ok;
			ST_IDLE: en_fcs = write_ok;
			default: en_fcs = 1'b0;
		endcase
	end

	// engine continues from its register only inside an open block
	assign sel = (state_q == ST_WRITE) || (state_q == ST_IDLE);

	// last word of a block, or flush of a partial block
	assign crc_ready = (en_fcs && count_max) || ((state_q == ST_TASK_DONE) && block_open);

	// next state
	always_comb begin
		state_d = state_q;
		if (pause) begin
			// park and keep count and running crc untouched
			state_d = ST_INIT;
		end else begin
			case (state_q)
				ST_INIT: begin
					if (unpause) begin
						// resume a partial block, otherwise nothing to resume
						state_d = block_open ? ST_IDLE : ST_INIT;
					end else if (en_fcs) begin
						// first word taken straight from init
						state_d = ST_WRITE;
					end else if (en_fprint && !block_open) begin
						// arm for the first word of a new task
						state_d = ST_FIRST_WRITE;
					end
				end
				ST_FIRST_WRITE, ST_BLOCK_DONE: begin
					// count is zero here so a falling enable has nothing to report
					if (!en_fprint) begin
						state_d = ST_INIT;
					end else if (en_fcs) begin
						state_d = ST_WRITE;
					end else begin
						state_d = ST_FIRST_WRITE;
					end
				end
				ST_WRITE, ST_IDLE: begin
					if (en_fcs && count_max) begin
						// block closes on this word
						state_d = ST_BLOCK_DONE;
					end else if (en_fcs) begin
						state_d = ST_WRITE;
					end else if (!en_fprint) begin
						// enable dropped mid block
						state_d = ST_TASK_DONE;
					end else begin
						state_d = ST_IDLE;
					end
				end
				ST_TASK_DONE: begin
					state_d = ST_INIT;
				end
				default: begin
					state_d = ST_INIT;
				end
			endcase
		end
	end

	// state register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= ST_INIT;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

// File: verilog/crc_pkg.sv
package crc_pkg;

	// processor bus word and crc register widths
	localparam int DATA_WIDTH = 32;
	localparam int CRC_WIDTH = 32;

	// one write from the processor bus
	typedef logic [DATA_WIDTH-1:0] data_word_t;

	// running or finished crc value
	typedef logic [CRC_WIDTH-1:0] crc_word_t;

	// word position inside a block
	localparam int COUNTER_WIDTH = 3;
	typedef logic [COUNTER_WIDTH-1:0] word_count_t;

	// a block fills the whole counter range
	localparam int BLOCK_WORDS = 2 ** COUNTER_WIDTH;

	// crc-32 generator, msb first and not reflected
	localparam crc_word_t CRC_POLY = 32'h04C11DB7;

	// every block starts from all ones
	localparam crc_word_t CRC_SEED = '1;

	// block sequencing states
	// init waits for en_fprint or sits parked after a pause
	// first_write and block_done reseed the engine on the next word
	// write and idle continue an open block
	// task_done flushes a partial block when en_fprint falls
	typedef enum logic [2:0] {
		ST_INIT,
		ST_FIRST_WRITE,
		ST_WRITE,
		ST_BLOCK_DONE,
		ST_IDLE,
		ST_TASK_DONE
	} fsm_state_t;

endpackage

// File: verilog/crc_result_port.sv
`timescale 1ns/1ps

module crc_result_port (
	input  logic               clk,
	input  logic               rst,
	input  logic               crc_ready,
	input  crc_pkg::crc_word_t crc_next,
	input  logic               res_ack,
	output logic               res_req,
	output crc_pkg::crc_word_t res_data,
	output logic               overrun
);

	import crc_pkg::*;

	// four phase handshake
	// hold has data but still waits for ack low before offering
	typedef enum logic [1:0] {
		PORT_EMPTY,
		PORT_OFFER,
		PORT_WAIT_LOW,
		PORT_HOLD
	} port_state_t;

	port_state_t state_q;
	crc_word_t data_q;

	// slot is free once the host has acknowledged
	logic can_load;

	assign can_load = (state_q == PORT_EMPTY) || (state_q == PORT_WAIT_LOW);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= PORT_EMPTY;
			overrun <= 1'b0;
		end else begin
			case (state_q)
				PORT_EMPTY, PORT_WAIT_LOW: begin
					if (crc_ready) begin
						// ack still high means the last cycle is not closed yet
						state_q <= res_ack ? PORT_HOLD : PORT_OFFER;
					end else if (!res_ack) begin
						state_q <= PORT_EMPTY;
					end
				end
				PORT_OFFER: begin
					// host took the data so drop req
					if (res_ack) begin
						state_q <= PORT_WAIT_LOW;
					end
				end
				PORT_HOLD: begin
					if (!res_ack) begin
						state_q <= PORT_OFFER;
					end
				end
				default: begin
					state_q <= PORT_EMPTY;
				end
			endcase
			// unacknowledged result stays, the new one is lost
			if (crc_ready && !can_load) begin
				overrun <= 1'b1;
			end
		end
	end

	// result slot, only written while free so data is stable under req
	always_ff @(posedge clk) begin
		if (crc_ready && can_load) begin
			data_q <= crc_next;
		end
	end

	assign res_req = (state_q == PORT_OFFER);
	assign res_data = data_q;

endmodule

// File: verilog/crc_word_counter.sv
`timescale 1ns/1ps

module crc_word_counter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 en_fcs,
	input  logic                 crc_ready,
	output crc_pkg::word_count_t count,
	output logic                 count_max
);

	import crc_pkg::*;

	word_count_t count_q;

	// words absorbed so far in the current block
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count_q <= '0;
		end else if (crc_ready) begin
			// block finished or flushed
			count_q <= '0;
		end else if (en_fcs) begin
			count_q <= count_q + word_count_t'(1);
		end
	end

	assign count = count_q;

	// next absorbed word is the last one of the block
	assign count_max = (count_q == word_count_t'(BLOCK_WORDS - 1));

endmodule
